// ==== project.f ====
+incdir+.
gb_cart_pkg.sv
gb_cart_decode.sv
gb_cart_bank_regs.sv
gb_cart_map.sv
gb_cart_mapper.sv
gb_cart_asserts.sv
tb_gb_cart_mapper.sv

// ==== tb_gb_cart_mapper.sv ====
// ------------------------------------------------
// directed testbench for the cartridge mapper
// ------------------------------------------------
`timescale 1ns/1ns
`include "gb_cart_cfg.svh"

module tb_gb_cart_mapper;

	logic                      clk_sys;
	logic                      reset;
	logic                      hdr_wr;
	logic [`GB_ROM_ADDR_W-1:0] hdr_addr;
	logic [15:0]               hdr_data;
	logic                      cpu_ce;
	logic [`GB_ADDR_W-1:0]     cart_addr;
	logic                      cart_rd;
	logic                      cart_wr;
	logic [`GB_DATA_W-1:0]     cart_di;
	logic [`GB_DATA_W-1:0]     rom_data;
	logic [`GB_ROM_ADDR_W-1:0] rom_addr;
	logic                      rom_rd;
	logic [`GB_DATA_W-1:0]     cart_do;

	int errors = 0;
	int checks = 0;
	// counts rising edges so a read can wait for its data cycle
	int cyc_cnt = 0;
	logic [31:0] lfsr = 32'h0779_5e73;
	// last byte written to each offset of ram bank 0
	logic [7:0] ram_model [0:8191];

	gb_cart_mapper uut (.*);

	// rom image folds the low address byte with the bank number
	function automatic logic [7:0] rom_model(input logic [21:0] a);
		return a[7:0] ^ a[21:14];
	endfunction

	assign rom_data = rom_model(rom_addr);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys)
		cyc_cnt <= cyc_cnt + 1;

	// ------------------------------------------------
	// helpers
	// ------------------------------------------------

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// rom byte address of a 16k bank window
	function automatic logic [21:0] bank_addr(input logic [6:0] bank, input logic [15:0] addr);
		return {1'b0, bank, addr[13:0]};
	endfunction

	// inputs change just after the rising edge
	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	// a rom read is held on the bus while reset is high
	task automatic apply_reset;
		next_cycle();
		reset = 1'b1;
		cpu_ce = 1'b1;
		cart_rd = 1'b1;
		cart_addr = 16'h4000;
		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		cpu_ce = 1'b0;
		cart_rd = 1'b0;
	endtask

	task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------
	// bus tasks
	// ------------------------------------------------

	// type word at 146 and size word at 148
	task automatic load_header(input logic [7:0] ctype, input logic [7:0] rsize,
		input logic [7:0] asize);
		next_cycle();
		hdr_wr = 1'b1;
		hdr_addr = `GB_HDR_TYPE_ADDR;
		hdr_data = {ctype, 8'h00};
		next_cycle();
		hdr_addr = `GB_HDR_SIZE_ADDR;
		hdr_data = {asize, rsize};
		next_cycle();
		hdr_wr = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		next_cycle();
		cpu_ce = 1'b1;
		cart_wr = 1'b1;
		cart_addr = addr;
		cart_di = data;
		next_cycle();
		cpu_ce = 1'b0;
		cart_wr = 1'b0;
	endtask

	// rom_addr is checked in the strobe cycle and cart_do in the next one
	task automatic check_rom_map(input logic [15:0] addr, input logic [21:0] exp);
		int tmo;
		next_cycle();
		cpu_ce = 1'b1;
		cart_rd = 1'b1;
		cart_addr = addr;
		tmo = 0;
		while (!rom_rd && tmo < 2) begin
			#1;
			tmo++;
		end
		checks++;
		assert (rom_rd) else begin
			errors++;
			$display("rom_rd never rose for the read at %h", addr);
		end
		@(negedge clk_sys);
		expect_equal("rom_addr", rom_addr, exp);
		next_cycle();
		cpu_ce = 1'b0;
		cart_rd = 1'b0;
		@(negedge clk_sys);
		expect_equal("cart_do", cart_do, rom_model(exp));
	endtask

	// cartridge ram read with data one cycle after the strobe
	task automatic cpu_read(input logic [15:0] addr, input logic [7:0] exp);
		int start;
		int tmo;
		next_cycle();
		cpu_ce = 1'b1;
		cart_rd = 1'b1;
		cart_addr = addr;
		start = cyc_cnt;
		tmo = 0;
		// odd offsets stay clear of the clock edge
		while (cyc_cnt == start && tmo < 8) begin
			#2;
			tmo++;
		end
		cpu_ce = 1'b0;
		cart_rd = 1'b0;
		checks++;
		assert (cyc_cnt != start) else begin
			errors++;
			$display("timed out waiting for the data cycle of the read at %h", addr);
		end
		@(negedge clk_sys);
		expect_equal("cart_do", cart_do, exp);
	endtask

	// ------------------------------------------------
	// directed tests
	// ------------------------------------------------

	task automatic no_mapper_reads;
		apply_reset();
		load_header(8'h00, 8'h00, 8'h00);
		check_rom_map(16'h0000, 22'h000000);
		check_rom_map(16'h7fff, 22'h007fff);
	endtask

	task automatic mbc1_rom_banks;
		apply_reset();
		load_header(8'h01, 8'h02, 8'h00);
		// 0c under mask 7 leaves bank 4
		cpu_write(16'h2000, 8'h0c);
		check_rom_map(16'h4123, bank_addr(7'd4, 16'h4123));
		cpu_write(16'h2000, 8'h00);
		check_rom_map(16'h4123, bank_addr(7'd1, 16'h4123));
		// bit 5 alone is still bank 0 in the low five bits
		cpu_write(16'h2000, 8'h20);
		check_rom_map(16'h4123, bank_addr(7'd1, 16'h4123));
		check_rom_map(16'h1234, 22'h001234);
	endtask

	task automatic mbc1_mode_switch;
		apply_reset();
		load_header(8'h03, 8'h06, 8'h03);
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'h2000, 8'h03);
		cpu_write(16'h4000, 8'h02);
		// mode 0, ram bank 2 becomes rom bank bit 6
		check_rom_map(16'h4000, bank_addr(7'h43, 16'h4000));
		// this byte lands in ram bank 0
		cpu_write(16'ha010, 8'haa);
		cpu_write(16'h6000, 8'h01);
		check_rom_map(16'h4000, bank_addr(7'h03, 16'h4000));
		cpu_write(16'ha010, 8'h55);
		cpu_read(16'ha010, 8'h55);
		cpu_write(16'h4000, 8'h00);
		cpu_read(16'ha010, 8'haa);
		cpu_write(16'h4000, 8'h02);
		cpu_read(16'ha010, 8'h55);
	endtask

	task automatic ram_enable_gate;
		logic [15:0] addr_q [$];
		logic [15:0] a;
		logic [7:0] d;
		apply_reset();
		load_header(8'h03, 8'h00, 8'h03);
		cpu_read(16'ha000, 8'hff);
		cpu_write(16'h0000, 8'h0a);
		for (int i = 0; i < 8; i++) begin
			a = 16'ha000 | 16'(random_bits(13));
			d = 8'(random_bits(8));
			cpu_write(a, d);
			ram_model[a[12:0]] = d;
			addr_q.push_back(a);
		end
		foreach (addr_q[i])
			cpu_read(addr_q[i], ram_model[addr_q[i][12:0]]);
		// any other nibble closes the ram
		cpu_write(16'h0000, 8'h00);
		cpu_read(addr_q[0], 8'hff);
	endtask

	task automatic mapper_specials;
		// mbc5 keeps bank 0 in the upper window
		apply_reset();
		load_header(8'h19, 8'h06, 8'h00);
		cpu_write(16'h2000, 8'h00);
		check_rom_map(16'h4567, bank_addr(7'd0, 16'h4567));
		// mbc2 ram is four bits wide
		apply_reset();
		load_header(8'h06, 8'h00, 8'h00);
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'ha005, 8'h3c);
		cpu_read(16'ha005, 8'hfc);
		// mbc3 select 08 maps the rtc over the ram
		apply_reset();
		load_header(8'h13, 8'h00, 8'h03);
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'h4000, 8'h01);
		cpu_write(16'ha100, 8'h5a);
		cpu_write(16'h4000, 8'h08);
		cpu_read(16'ha100, 8'h00);
		cpu_write(16'h4000, 8'h01);
		cpu_read(16'ha100, 8'h5a);
	endtask

	initial begin
		reset = 1'b1;
		hdr_wr = 1'b0;
		hdr_addr = '0;
		hdr_data = '0;
		cpu_ce = 1'b0;
		cart_addr = '0;
		cart_rd = 1'b0;
		cart_wr = 1'b0;
		cart_di = '0;
		apply_reset();
		no_mapper_reads();
		mbc1_rom_banks();
		mbc1_mode_switch();
		ram_enable_gate();
		mapper_specials();
		next_cycle();
		// bound property failures count as errors too
		errors += uut.u_asserts.fail_cnt;
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== gb_cart_asserts.sv ====
// ------------------------------------------------
// concurrent checks bound into the mapper top level
// ------------------------------------------------
`timescale 1ns/1ns
`include "gb_cart_cfg.svh"

module gb_cart_asserts (
	input logic                      clk_sys,
	input logic                      reset,
	input logic                      cpu_ce,
	input logic                      cart_rd,
	input logic [`GB_ADDR_W-1:0]     cart_addr,
	input gb_cart_pkg::mbc_kind_t    mbc_kind,
	input logic                      ram_enable,
	input logic [`GB_ROM_ADDR_W-1:0] rom_addr,
	input logic                      rom_rd,
	input logic [`GB_DATA_W-1:0]     cart_do
);
	import gb_cart_pkg::*;

	// failed properties so far
	int fail_cnt = 0;

	// no rom strobe while the core is held in reset
	rom_rd_in_reset: assert property (@(posedge clk_sys) reset |-> !rom_rd)
		else begin
			$error("rom_rd high while reset is asserted");
			fail_cnt = fail_cnt + 1;
		end

	// with no header the upper rom window maps one to one
	linear_upper_map: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_ce && cart_rd && cart_addr[15:14] == 2'b01 && mbc_kind == MBC_NONE)
		|-> rom_addr == {6'd0, cart_addr})
		else begin
			$error("rom_addr not linear for an upper window read without a mapper");
			fail_cnt = fail_cnt + 1;
		end

	// closed cartridge ram reads back all ones one cycle later
	closed_ram_read: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu_ce && cart_rd && cart_addr[15:13] == `GB_WIN_CRAM && !ram_enable)
		|=> cart_do == 8'hff)
		else begin
			$error("read of disabled cartridge ram did not return ff");
			fail_cnt = fail_cnt + 1;
		end

endmodule

bind gb_cart_mapper gb_cart_asserts u_asserts (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.cpu_ce     (cpu_ce),
	.cart_rd    (cart_rd),
	.cart_addr  (cart_addr),
	.mbc_kind   (mbc_kind),
	.ram_enable (ram_enable),
	.rom_addr   (rom_addr),
	.rom_rd     (rom_rd),
	.cart_do    (cart_do)
);

// ==== gb_cart_mapper.sv ====
// ------------------------------------------------
// cartridge memory bank controller top level
// ------------------------------------------------
`timescale 1ns/1ns
`include "gb_cart_cfg.svh"

module gb_cart_mapper (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      hdr_wr,
	input  logic [`GB_ROM_ADDR_W-1:0] hdr_addr,
	input  logic [15:0]               hdr_data,
	input  logic                      cpu_ce,
	input  logic [`GB_ADDR_W-1:0]     cart_addr,
	input  logic                      cart_rd,
	input  logic                      cart_wr,
	input  logic [`GB_DATA_W-1:0]     cart_di,
	input  logic [`GB_DATA_W-1:0]     rom_data,
	output logic [`GB_ROM_ADDR_W-1:0] rom_addr,
	output logic                      rom_rd,
	output logic [`GB_DATA_W-1:0]     cart_do
);
	import gb_cart_pkg::*;

	// decode to execute and result
	mbc_kind_t                 mbc_kind;
	logic [`GB_ROM_BANK_W-1:0] rom_mask;
	logic [`GB_RAM_BANK_W-1:0] ram_mask;
	cart_cmd_t                 cmd;

	// execute to result
	logic [`GB_ROM_BANK_W-1:0] rom_bank;
	logic [`GB_RAM_BANK_W-1:0] ram_bank;
	logic                      mbc1_mode;
	logic                      rtc_mode;
	logic                      ram_enable;

	gb_cart_decode u_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.hdr_wr    (hdr_wr),
		.hdr_addr  (hdr_addr),
		.hdr_data  (hdr_data),
		.cpu_ce    (cpu_ce),
		.cart_wr   (cart_wr),
		.cart_addr (cart_addr),
		.mbc_kind  (mbc_kind),
		.rom_mask  (rom_mask),
		.ram_mask  (ram_mask),
		.cmd       (cmd)
	);

	gb_cart_bank_regs u_bank_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mbc_kind   (mbc_kind),
		.cmd        (cmd),
		.cart_di    (cart_di),
		.rom_bank   (rom_bank),
		.ram_bank   (ram_bank),
		.mbc1_mode  (mbc1_mode),
		.rtc_mode   (rtc_mode),
		.ram_enable (ram_enable)
	);

	gb_cart_map u_map (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_ce     (cpu_ce),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_di    (cart_di),
		.mbc_kind   (mbc_kind),
		.rom_mask   (rom_mask),
		.ram_mask   (ram_mask),
		.rom_bank   (rom_bank),
		.ram_bank   (ram_bank),
		.mbc1_mode  (mbc1_mode),
		.rtc_mode   (rtc_mode),
		.ram_enable (ram_enable),
		.rom_data   (rom_data),
		.rom_addr   (rom_addr),
		.rom_rd     (rom_rd),
		.cart_do    (cart_do)
	);

endmodule

// ==== gb_cart_map.sv ====
// ------------------------------------------------
// cpu address to rom and cartridge ram mapping
// holds the 32 KB ram and builds cpu read data
// ------------------------------------------------
`timescale 1ns/1ns
`include "gb_cart_cfg.svh"

module gb_cart_map (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      cpu_ce,
	input  logic [`GB_ADDR_W-1:0]     cart_addr,
	input  logic                      cart_rd,
	input  logic                      cart_wr,
	input  logic [`GB_DATA_W-1:0]     cart_di,
	input  gb_cart_pkg::mbc_kind_t    mbc_kind,
	input  logic [`GB_ROM_BANK_W-1:0] rom_mask,
	input  logic [`GB_RAM_BANK_W-1:0] ram_mask,
	input  logic [`GB_ROM_BANK_W-1:0] rom_bank,
	input  logic [`GB_RAM_BANK_W-1:0] ram_bank,
	input  logic                      mbc1_mode,
	input  logic                      rtc_mode,
	input  logic                      ram_enable,
	input  logic [`GB_DATA_W-1:0]     rom_data,
	output logic [`GB_ROM_ADDR_W-1:0] rom_addr,
	output logic                      rom_rd,
	output logic [`GB_DATA_W-1:0]     cart_do
);
	import gb_cart_pkg::*;

	// rom side
	logic [`GB_ROM_BANK_W-1:0] mbc1_bank;
	logic [`GB_ROM_BANK_W-1:0] hi_bank;
	logic [`GB_ROM_BANK_W-1:0] sel_bank;

	// ram side
	logic                       is_cram;
	logic [`GB_RAM_BANK_W-1:0]  cram_bank;
	logic [`GB_CRAM_ADDR_W-1:0] cram_addr;
	logic [`GB_DATA_W-1:0]      cram [0:(1 << `GB_CRAM_ADDR_W)-1];
	logic [`GB_DATA_W-1:0]      cram_q;

	// read format flags taken with the ram word
	logic rd_off;
	logic rd_mbc2;
	logic rd_rtc;
	// last cpu read went to a000-bfff
	logic last_cram;

	// ------------------------------------------------
	// rom mapping
	// ------------------------------------------------

	// in mode 0 the ram bank drives rom bank bits 6:5
	assign mbc1_bank = {mbc1_mode ? 2'b00 : ram_bank, rom_bank[4:0]};

	always_comb begin
		case (mbc_kind)
			MBC_1: hi_bank = mbc1_bank;
			// mbc2 has a 4 bit bank register
			MBC_2: hi_bank = {3'b000, rom_bank[3:0]};
			default: hi_bank = rom_bank;
		endcase
	end

	// 0000-3fff always sees bank 0
	assign sel_bank = cart_addr[14] ? (hi_bank & rom_mask) : '0;

	always_comb begin
		if (mbc_kind == MBC_NONE)
			rom_addr = {{(`GB_ROM_ADDR_W-15){1'b0}}, cart_addr[14:0]};
		else
			rom_addr = {{(`GB_ROM_ADDR_W-`GB_ROM_BANK_W-14){1'b0}}, sel_bank,
				cart_addr[13:0]};
	end

	// no rom strobe while the core is held in reset
	assign rom_rd = !reset && cpu_ce && cart_rd && !cart_addr[15];

	// ------------------------------------------------
	// cartridge ram
	// ------------------------------------------------

	assign is_cram = (cart_addr[15:13] == `GB_WIN_CRAM);

	// mbc1 banks its ram only in mode 1
	always_comb begin
		case (mbc_kind)
			MBC_1: cram_bank = mbc1_mode ? (ram_bank & ram_mask) : '0;
			MBC_3, MBC_5: cram_bank = ram_bank & ram_mask;
			default: cram_bank = '0;
		endcase
	end

	assign cram_addr = {cram_bank, cart_addr[12:0]};

	// single port with registered read
	always_ff @(posedge clk_sys) begin
		if (cpu_ce && is_cram) begin
			if (cart_wr)
				cram[cram_addr] <= cart_di;
			if (cart_rd) begin
				cram_q <= cram[cram_addr];
				rd_off <= !ram_enable;
				rd_mbc2 <= (mbc_kind == MBC_2);
				rd_rtc <= rtc_mode;
			end
		end
	end

	// ------------------------------------------------
	// cpu read data
	// ------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset)
			last_cram <= 1'b0;
		else if (cpu_ce && cart_rd)
			last_cram <= is_cram;
	end

	always_comb begin
		if (!last_cram)
			cart_do = rom_data;
		else if (rd_off)
			cart_do = 8'hff;
		// 4 bit ram so the top nibble floats high
		else if (rd_mbc2)
			cart_do = {4'hf, cram_q[3:0]};
		// clock registers are not modelled
		else if (rd_rtc)
			cart_do = 8'h00;
		else
			cart_do = cram_q;
	end

endmodule

// ==== gb_cart_bank_regs.sv ====
// ------------------------------------------------
// mapper bank registers and mode flags
// ------------------------------------------------
`timescale 1ns/1ns
`include "gb_cart_cfg.svh"

module gb_cart_bank_regs (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  gb_cart_pkg::mbc_kind_t    mbc_kind,
	input  gb_cart_pkg::cart_cmd_t    cmd,
	input  logic [`GB_DATA_W-1:0]     cart_di,
	output logic [`GB_ROM_BANK_W-1:0] rom_bank,
	output logic [`GB_RAM_BANK_W-1:0] ram_bank,
	output logic                      mbc1_mode,
	output logic                      rtc_mode,
	output logic                      ram_enable
);
	import gb_cart_pkg::*;

	// bank 0 written to the rom bank register
	logic rom_zero;
	// mbc3 register select with bit 3 picks the rtc
	logic rtc_sel;

	assign rom_zero = (cart_di[4:0] == 5'd0);
	assign rtc_sel = (mbc_kind == MBC_3) && cart_di[3];

	// ------------------------------------------------
	// rom bank
	// ------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank <= `GB_ROM_BANK_RESET;
		end else if (cmd == CMD_ROM_BANK) begin
			// every mapper but mbc5 turns bank 0 into bank 1
			// the check only looks at the low five bits
			if (rom_zero && (mbc_kind != MBC_5))
				rom_bank <= `GB_ROM_BANK_RESET;
			else
				rom_bank <= cart_di[6:0];
		end
	end

	// ------------------------------------------------
	// ram bank and rtc select
	// ------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_bank <= '0;
			rtc_mode <= 1'b0;
		end else if (cmd == CMD_RAM_BANK) begin
			if (rtc_sel) begin
				// ram bank is kept while the rtc is mapped
				rtc_mode <= 1'b1;
			end else begin
				rtc_mode <= 1'b0;
				ram_bank <= cart_di[1:0];
			end
		end
	end

	// ------------------------------------------------
	// banking mode and ram enable
	// ------------------------------------------------

	// mode 0 gives ram bank bits to rom bank 6:5
	// mode 1 gives them to the cartridge ram
	always_ff @(posedge clk_sys) begin
		if (reset)
			mbc1_mode <= 1'b0;
		else if (cmd == CMD_MODE)
			mbc1_mode <= cart_di[0];
	end

	// any other nibble closes the ram again
	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_enable <= 1'b0;
		else if (cmd == CMD_RAM_ENABLE)
			ram_enable <= (cart_di[3:0] == `GB_RAM_ENABLE_KEY);
	end

endmodule

// ==== gb_cart_decode.sv ====
// ------------------------------------------------
// cartridge header capture and mapper classification
// turns cpu writes in 0000-7fff into mapper commands
// ------------------------------------------------
`timescale 1ns/1ns
`include "gb_cart_cfg.svh"

module gb_cart_decode (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      hdr_wr,
	input  logic [`GB_ROM_ADDR_W-1:0] hdr_addr,
	input  logic [15:0]               hdr_data,
	input  logic                      cpu_ce,
	input  logic                      cart_wr,
	input  logic [`GB_ADDR_W-1:0]     cart_addr,
	output gb_cart_pkg::mbc_kind_t    mbc_kind,
	output logic [`GB_ROM_BANK_W-1:0] rom_mask,
	output logic [`GB_RAM_BANK_W-1:0] ram_mask,
	output gb_cart_pkg::cart_cmd_t    cmd
);
	import gb_cart_pkg::*;

	// raw header bytes
	logic [`GB_DATA_W-1:0] cart_type;
	logic [`GB_DATA_W-1:0] rom_size;
	logic [`GB_DATA_W-1:0] ram_size;

	// cpu address bits 15:13
	logic [2:0] win;

	// ------------------------------------------------
	// header capture
	// ------------------------------------------------

	// loader writes whole words at even addresses
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= '0;
			rom_size <= '0;
			ram_size <= '0;
		end else if (hdr_wr) begin
			// type byte 147 in the upper half
			if (hdr_addr == `GB_HDR_TYPE_ADDR)
				cart_type <= hdr_data[15:8];
			// rom size 148 low and ram size 149 high
			if (hdr_addr == `GB_HDR_SIZE_ADDR) begin
				rom_size <= hdr_data[7:0];
				ram_size <= hdr_data[15:8];
			end
		end
	end

	// ------------------------------------------------
	// mapper family and size masks
	// ------------------------------------------------

	always_comb begin
		case (cart_type)
			8'h01, 8'h02, 8'h03: mbc_kind = MBC_1;
			8'h05, 8'h06: mbc_kind = MBC_2;
			8'h0f, 8'h10, 8'h11, 8'h12, 8'h13: mbc_kind = MBC_3;
			8'h19, 8'h1a, 8'h1b, 8'h1c, 8'h1d, 8'h1e: mbc_kind = MBC_5;
			default: mbc_kind = MBC_NONE;
		endcase
	end

	// bank mask for rom mirroring
	// size n means 2 << n banks of 16k
	always_comb begin
		case (rom_size)
			8'h00: rom_mask = 7'h01;
			8'h01: rom_mask = 7'h03;
			8'h02: rom_mask = 7'h07;
			8'h03: rom_mask = 7'h0f;
			8'h04: rom_mask = 7'h1f;
			8'h05: rom_mask = 7'h3f;
			8'h06: rom_mask = 7'h7f;
			// 72 80 and 96 bank parts
			8'h52: rom_mask = 7'h47;
			8'h53: rom_mask = 7'h4f;
			8'h54: rom_mask = 7'h5f;
			default: rom_mask = 7'h5f;
		endcase
	end

	// only the 32k part has four banks
	assign ram_mask = (ram_size >= 8'h03) ? 2'b11 : 2'b00;

	// ------------------------------------------------
	// cpu register window
	// ------------------------------------------------

	assign win = cart_addr[`GB_ADDR_W-1 -: 3];

	always_comb begin
		cmd = CMD_NONE;
		if (cpu_ce && cart_wr) begin
			case (win)
				`GB_WIN_RAM_ENABLE: cmd = CMD_RAM_ENABLE;
				`GB_WIN_ROM_BANK: cmd = CMD_ROM_BANK;
				`GB_WIN_RAM_BANK: cmd = CMD_RAM_BANK;
				// banking mode exists on mbc1 only
				`GB_WIN_MODE: begin
					if (mbc_kind == MBC_1)
						cmd = CMD_MODE;
				end
				default: cmd = CMD_NONE;
			endcase
		end
	end

endmodule

// ==== gb_cart_pkg.sv ====
// ------------------------------------------------
// shared types of the cartridge mapper
// ------------------------------------------------
package gb_cart_pkg;

	// ------------------------------------------------
	// mapper family
	// ------------------------------------------------

	// decoded from the header type byte at 147
	// mbc4 and the odd mappers fall into none
	typedef enum logic [2:0] {
		// plain 32k rom with linear mapping
		MBC_NONE = 3'd0,
		// types 01 to 03
		MBC_1 = 3'd1,
		// types 05 and 06 with 4 bit internal ram
		MBC_2 = 3'd2,
		// types 0f to 13 with rtc
		MBC_3 = 3'd3,
		// types 19 to 1e and bank 0 is a legal bank here
		MBC_5 = 3'd4
	} mbc_kind_t;

	// ------------------------------------------------
	// decoded cpu write
	// ------------------------------------------------

	// one command per qualified write into 0000-7fff
	typedef enum logic [2:0] {
		// no write this cycle or write outside the window
		CMD_NONE = 3'd0,
		// 0000-1fff
		CMD_RAM_ENABLE = 3'd1,
		// 2000-3fff
		CMD_ROM_BANK = 3'd2,
		// 4000-5fff
		CMD_RAM_BANK = 3'd3,
		// 6000-7fff and only decoded for mbc1
		CMD_MODE = 3'd4
	} cart_cmd_t;

endpackage

// ==== gb_cart_cfg.svh ====
// ------------------------------------------------
// cartridge mapper widths and header offsets
// register window codes and reset values
// ------------------------------------------------
`ifndef GB_CART_CFG_SVH
`define GB_CART_CFG_SVH

// cpu side bus
`define GB_ADDR_W 16
`define GB_DATA_W 8

// rom byte address and bank register
`define GB_ROM_ADDR_W 22
`define GB_ROM_BANK_W 7

// cartridge ram bank select and byte address (32 KB)
`define GB_RAM_BANK_W 2
`define GB_CRAM_ADDR_W 15

// header words as the loader presents them
// type byte is the high half of the word at 146
// rom size is the low half and ram size the high half of the word at 148
`define GB_HDR_TYPE_ADDR 22'h000146
`define GB_HDR_SIZE_ADDR 22'h000148

// cpu address bits 15:13 for each window
`define GB_WIN_RAM_ENABLE 3'b000
`define GB_WIN_ROM_BANK 3'b001
`define GB_WIN_RAM_BANK 3'b010
`define GB_WIN_MODE 3'b011
`define GB_WIN_CRAM 3'b101

// low nibble that opens cartridge ram
`define GB_RAM_ENABLE_KEY 4'ha
`define GB_ROM_BANK_RESET 7'd1

`endif
